// File: cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// words in each of imem and dmem
`define MEM_WORDS 1024

// store here raises io_valid instead of writing dmem
`define IO_OUT_ADDR 32'h8000_0008

// tohost csr number
`define CSR_TOHOST 12'h51E

`endif

// File: cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [$clog2(`MEM_WORDS)-1:0] mem_addr_t;
    typedef logic [3:0] byte_mask_t;
    typedef logic [3:0] alu_op_t;

    // alu operation codes
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // rv32i major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // add x0, x0, x0
    localparam word_t NOP = 32'h0000_0033;

endpackage

// File: word_ram.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module word_ram (
    input  logic                clk,
    input  cpu_pkg::byte_mask_t we,
    input  cpu_pkg::mem_addr_t  waddr,
    input  cpu_pkg::word_t      wdata,
    input  cpu_pkg::mem_addr_t  raddr,
    output cpu_pkg::word_t      rdata
);

    cpu_pkg::word_t mem [`MEM_WORDS];

    // one lane per write-mask bit
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // registered read, data shows up next cycle
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               we,
    input  cpu_pkg::reg_addr_t ra1,
    input  cpu_pkg::reg_addr_t ra2,
    input  cpu_pkg::reg_addr_t wa,
    input  cpu_pkg::word_t     wd,
    output cpu_pkg::word_t     rd1,
    output cpu_pkg::word_t     rd2
);

    cpu_pkg::word_t regs [31:1];
    logic           wr_live;

    // x0 is never stored
    assign wr_live = we && (wa != 5'd0);

    always_ff @(posedge clk) begin
        if (wr_live) begin
            regs[wa] <= wd;
        end
    end

    // same-cycle writeback goes straight through to stage 1
    assign rd1 = (ra1 == 5'd0) ? '0 : (wr_live && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : (wr_live && wa == ra2) ? wd : regs[ra2];

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_t op,
    output cpu_pkg::word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:    result = a + b;
            cpu_pkg::ALU_SUB:    result = a - b;
            cpu_pkg::ALU_SLL:    result = a << shamt;
            cpu_pkg::ALU_SLT:    result = {31'd0, $signed(a) < $signed(b)};
            cpu_pkg::ALU_SLTU:   result = {31'd0, a < b};
            cpu_pkg::ALU_XOR:    result = a ^ b;
            cpu_pkg::ALU_SRL:    result = a >> shamt;
            // arithmetic shift keeps the sign bit
            cpu_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
            cpu_pkg::ALU_OR:     result = a | b;
            cpu_pkg::ALU_AND:    result = a & b;
            cpu_pkg::ALU_PASS_B: result = b;
            default:             result = a + b;
        endcase
    end

endmodule

// File: imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  cpu_pkg::word_t instr,
    output cpu_pkg::word_t imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (instr[6:0])
            cpu_pkg::OPC_OP_IMM, cpu_pkg::OPC_LOAD, cpu_pkg::OPC_JALR, cpu_pkg::OPC_SYSTEM:
                imm = {{20{sign}}, instr[31:20]};
            cpu_pkg::OPC_STORE:
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            cpu_pkg::OPC_BRANCH:
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            // upper immediate, low 12 bits zero
            cpu_pkg::OPC_LUI, cpu_pkg::OPC_AUIPC:
                imm = {instr[31:12], 12'd0};
            cpu_pkg::OPC_JAL:
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// File: decode.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decode (
    input  cpu_pkg::word_t   instr,
    input  cpu_pkg::word_t   instr_s3,
    input  cpu_pkg::word_t   rs1_val,
    input  cpu_pkg::word_t   rs2_val,
    output logic [1:0]       fwd_sel_1,
    output logic [1:0]       fwd_sel_2,
    output logic             a_sel,
    output logic             b_sel,
    output cpu_pkg::alu_op_t alu_op,
    output logic             branch_taken,
    output logic             jump,
    output logic             store_en,
    output logic             csr_we
);

    logic [6:0]         opcode;
    logic [6:0]         opcode_s3;
    logic [2:0]         funct3;
    cpu_pkg::reg_addr_t rd_s3;
    logic               s3_alu_wr;
    logic               s3_load_wr;
    logic               cond;
    cpu_pkg::alu_op_t   arith_op;

    // 0 registered, 1 stage-3 alu result, 2 stage-3 load data
    function automatic logic [1:0] fwd(input cpu_pkg::reg_addr_t rs,
                                       input cpu_pkg::reg_addr_t rd,
                                       input logic alu_wr, input logic load_wr);
        logic [1:0] sel;
        sel = 2'd0;
        if (rs == rd && load_wr) begin
            sel = 2'd2;
        end else if (rs == rd && alu_wr) begin
            sel = 2'd1;
        end
        return sel;
    endfunction

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign opcode_s3 = instr_s3[6:0];
    assign rd_s3     = instr_s3[11:7];

    // jal/jalr in stage 3 always has a bubble behind it
    assign s3_alu_wr = (opcode_s3 inside {cpu_pkg::OPC_LUI, cpu_pkg::OPC_AUIPC,
                        cpu_pkg::OPC_OP, cpu_pkg::OPC_OP_IMM}) && (rd_s3 != 5'd0);
    assign s3_load_wr = (opcode_s3 == cpu_pkg::OPC_LOAD) && (rd_s3 != 5'd0);

    assign fwd_sel_1 = fwd(instr[19:15], rd_s3, s3_alu_wr, s3_load_wr);
    assign fwd_sel_2 = fwd(instr[24:20], rd_s3, s3_alu_wr, s3_load_wr);

    // bit 30 selects sub and sra, sub only for register ops
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == cpu_pkg::OPC_OP && instr[30]) ?
                                cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            3'b001:  arith_op = cpu_pkg::ALU_SLL;
            3'b010:  arith_op = cpu_pkg::ALU_SLT;
            3'b011:  arith_op = cpu_pkg::ALU_SLTU;
            3'b100:  arith_op = cpu_pkg::ALU_XOR;
            3'b101:  arith_op = instr[30] ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            3'b110:  arith_op = cpu_pkg::ALU_OR;
            default: arith_op = cpu_pkg::ALU_AND;
        endcase
    end

    // a_sel picks pc, b_sel picks the immediate
    always_comb begin
        a_sel  = 1'b0;
        b_sel  = 1'b1;
        alu_op = cpu_pkg::ALU_ADD;
        case (opcode)
            cpu_pkg::OPC_LUI:    alu_op = cpu_pkg::ALU_PASS_B;
            cpu_pkg::OPC_AUIPC, cpu_pkg::OPC_JAL, cpu_pkg::OPC_BRANCH: a_sel = 1'b1;
            cpu_pkg::OPC_OP_IMM: alu_op = arith_op;
            cpu_pkg::OPC_OP: begin
                b_sel  = 1'b0;
                alu_op = arith_op;
            end
            default: alu_op = cpu_pkg::ALU_ADD;
        endcase
    end

    // compare on forwarded operands
    always_comb begin
        case (funct3)
            3'b000:  cond = rs1_val == rs2_val;
            3'b001:  cond = rs1_val != rs2_val;
            3'b100:  cond = $signed(rs1_val) < $signed(rs2_val);
            3'b101:  cond = $signed(rs1_val) >= $signed(rs2_val);
            3'b110:  cond = rs1_val < rs2_val;
            default: cond = rs1_val >= rs2_val;
        endcase
    end

    assign branch_taken = (opcode == cpu_pkg::OPC_BRANCH) && cond;
    assign jump = (opcode == cpu_pkg::OPC_JAL) || (opcode == cpu_pkg::OPC_JALR);
    assign store_en = opcode == cpu_pkg::OPC_STORE;
    assign csr_we = (opcode == cpu_pkg::OPC_SYSTEM) && (funct3 == 3'b001) &&
                    (instr[31:20] == `CSR_TOHOST);

endmodule

// File: mem_align.sv
`timescale 1ns/1ps

module mem_align (
    input  cpu_pkg::word_t      store_instr,
    input  cpu_pkg::word_t      store_addr,
    input  cpu_pkg::word_t      store_data,
    input  logic                store_en,
    output cpu_pkg::byte_mask_t store_mask,
    output cpu_pkg::word_t      store_wdata,
    input  cpu_pkg::word_t      load_instr,
    input  cpu_pkg::word_t      load_addr,
    input  cpu_pkg::word_t      mem_rdata,
    output cpu_pkg::word_t      load_value
);

    cpu_pkg::word_t shifted;

    // byte and half replicated across lanes, mask picks the live ones
    always_comb begin
        case (store_instr[13:12])
            2'b00: begin
                store_wdata = {4{store_data[7:0]}};
                store_mask  = 4'b0001 << store_addr[1:0];
            end
            2'b01: begin
                store_wdata = {2{store_data[15:0]}};
                store_mask  = store_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                store_wdata = store_data;
                store_mask  = 4'b1111;
            end
        endcase
        if (!store_en) begin
            store_mask = 4'b0000;
        end
    end

    // addressed byte moved down to bit 0
    assign shifted = mem_rdata >> {load_addr[1:0], 3'b000};

    always_comb begin
        case (load_instr[14:12])
            3'b000:  load_value = {{24{shifted[7]}}, shifted[7:0]};
            3'b001:  load_value = {{16{shifted[15]}}, shifted[15:0]};
            3'b100:  load_value = {24'd0, shifted[7:0]};
            3'b101:  load_value = {16'd0, shifted[15:0]};
            default: load_value = mem_rdata;
        endcase
    end

endmodule

// File: cpu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu (
    input  logic               clk,
    input  logic               rst,
    input  logic               prog_we,
    input  cpu_pkg::mem_addr_t prog_addr,
    input  cpu_pkg::word_t     prog_data,
    output logic               io_valid,
    output cpu_pkg::word_t     io_data,
    output logic               tohost_valid,
    output cpu_pkg::word_t     tohost
);

    localparam int AW = $bits(cpu_pkg::mem_addr_t);

    cpu_pkg::word_t      pc_next, pc, imem_rdata, instr_s1, imm_s1, rd1_s1, rd2_s1;
    cpu_pkg::word_t      instr_s2, pc_s2, rs1_s2, rs2_s2, imm_s2;
    cpu_pkg::word_t      op1, op2, alu_a, alu_b, alu_result, target;
    cpu_pkg::word_t      store_wdata, dmem_rdata, load_value;
    cpu_pkg::word_t      instr_s3, alu_s3, pc_s3, wb_data;
    cpu_pkg::byte_mask_t imem_we, dmem_we, store_mask;
    cpu_pkg::alu_op_t    alu_op;
    logic [1:0]          fwd_sel_1, fwd_sel_2;
    logic [6:0]          opcode_s3;
    logic                a_sel, b_sel, branch_taken, jump, store_en, csr_we;
    logic                ctrl_s2, is_io, reg_we;

    // stage 1: fetch, bubble, register read, immediate

    assign ctrl_s2 = jump || (instr_s2[6:0] == cpu_pkg::OPC_BRANCH);
    assign target  = {alu_result[31:1], 1'b0};

    // untaken branch refetches from pc_s2 + 4, which is the bubbled slot
    always_comb begin
        if (rst) begin
            pc_next = `RESET_PC;
        end else if (branch_taken || jump) begin
            pc_next = target;
        end else if (ctrl_s2) begin
            pc_next = pc_s2 + 32'd4;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    // program loading only while held in reset
    assign imem_we = {4{rst && prog_we}};

    word_ram imem (
        .clk(clk), .we(imem_we), .waddr(prog_addr), .wdata(prog_data),
        .raddr(pc_next[AW+1:2]), .rdata(imem_rdata)
    );

    assign instr_s1 = ctrl_s2 ? cpu_pkg::NOP : imem_rdata;

    imm_gen imm_gen_s1 (.instr(instr_s1), .imm(imm_s1));

    reg_file rf (
        .clk(clk), .we(reg_we),
        .ra1(instr_s1[19:15]), .ra2(instr_s1[24:20]), .wa(instr_s3[11:7]),
        .wd(wb_data), .rd1(rd1_s1), .rd2(rd2_s1)
    );

    // stage 2: execute, branch resolve, memory request

    decode dec (
        .instr(instr_s2), .instr_s3(instr_s3), .rs1_val(op1), .rs2_val(op2),
        .fwd_sel_1(fwd_sel_1), .fwd_sel_2(fwd_sel_2), .a_sel(a_sel), .b_sel(b_sel),
        .alu_op(alu_op), .branch_taken(branch_taken), .jump(jump),
        .store_en(store_en), .csr_we(csr_we)
    );

    always_comb begin
        case (fwd_sel_1)
            2'd1:    op1 = alu_s3;
            2'd2:    op1 = load_value;
            default: op1 = rs1_s2;
        endcase
        case (fwd_sel_2)
            2'd1:    op2 = alu_s3;
            2'd2:    op2 = load_value;
            default: op2 = rs2_s2;
        endcase
    end

    assign alu_a = a_sel ? pc_s2 : op1;
    assign alu_b = b_sel ? imm_s2 : op2;

    alu alu_s2 (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result));

    mem_align align (
        .store_instr(instr_s2), .store_addr(alu_result), .store_data(op2),
        .store_en(store_en), .store_mask(store_mask), .store_wdata(store_wdata),
        .load_instr(instr_s3), .load_addr(alu_s3), .mem_rdata(dmem_rdata),
        .load_value(load_value)
    );

    // io address is kept out of dmem
    assign is_io   = alu_result == `IO_OUT_ADDR;
    assign dmem_we = is_io ? 4'b0000 : store_mask;

    word_ram dmem (
        .clk(clk), .we(dmem_we), .waddr(alu_result[AW+1:2]), .wdata(store_wdata),
        .raddr(alu_result[AW+1:2]), .rdata(dmem_rdata)
    );

    // stage 3: writeback

    assign opcode_s3 = instr_s3[6:0];
    assign reg_we = opcode_s3 inside {cpu_pkg::OPC_LUI, cpu_pkg::OPC_AUIPC,
                    cpu_pkg::OPC_JAL, cpu_pkg::OPC_JALR, cpu_pkg::OPC_LOAD,
                    cpu_pkg::OPC_OP_IMM, cpu_pkg::OPC_OP};

    always_comb begin
        case (opcode_s3)
            cpu_pkg::OPC_LOAD:                   wb_data = load_value;
            cpu_pkg::OPC_JAL, cpu_pkg::OPC_JALR: wb_data = pc_s3 + 32'd4;
            default:                             wb_data = alu_s3;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instr_s2     <= cpu_pkg::NOP;
            instr_s3     <= cpu_pkg::NOP;
            io_valid     <= 1'b0;
            tohost_valid <= 1'b0;
            tohost       <= '0;
        end else begin
            instr_s2     <= instr_s1;
            instr_s3     <= instr_s2;
            io_valid     <= store_en && is_io;
            tohost_valid <= csr_we;
            if (csr_we) begin
                tohost <= op1;
            end
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        pc     <= pc_next;
        pc_s2  <= pc;
        rs1_s2 <= rd1_s1;
        rs2_s2 <= rd2_s1;
        imm_s2 <= imm_s1;
        alu_s3 <= alu_result;
        pc_s3  <= pc_s2;
        if (store_en && is_io) begin
            io_data <= op2;
        end
    end

endmodule

// File: tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu;

    localparam int NUM_TESTS = 5;

    logic               clk;
    logic               rst;
    logic               prog_we;
    cpu_pkg::mem_addr_t prog_addr;
    cpu_pkg::word_t     prog_data;
    logic               io_valid;
    cpu_pkg::word_t     io_data;
    logic               tohost_valid;
    cpu_pkg::word_t     tohost;

    integer         seed = 70;
    int             errors = 0;
    int             n_pass = 0;
    int             n_fail = 0;
    int             pulses = 0;
    cpu_pkg::word_t prog [$];
    cpu_pkg::word_t exp_q [$];
    cpu_pkg::word_t io_q [$];

    cpu DUT (
        .clk(clk), .rst(rst), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .io_valid(io_valid), .io_data(io_data),
        .tohost_valid(tohost_valid), .tohost(tohost)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // io writes and tohost pulses, sampled away from the active edge
    always @(negedge clk) begin
        if (io_valid) begin
            io_q.push_back(io_data);
        end
        if (tohost_valid) begin
            pulses++;
        end
    end

    function automatic cpu_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, cpu_pkg::OPC_OP};
    endfunction

    function automatic cpu_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic cpu_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], cpu_pkg::OPC_STORE};
    endfunction

    function automatic cpu_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpu_pkg::OPC_BRANCH};
    endfunction

    function automatic cpu_pkg::word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic cpu_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, cpu_pkg::OPC_JAL};
    endfunction

    function automatic cpu_pkg::word_t addi(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return enc_i(imm, rs1, 3'b000, rd, cpu_pkg::OPC_OP_IMM);
    endfunction

    function automatic cpu_pkg::word_t random_word();
        return $random(seed);
    endfunction

    function automatic cpu_pkg::word_t pc_of(input int n);
        return `RESET_PC + cpu_pkg::word_t'(n * 4);
    endfunction

    // signed less-than from the sign bits
    function automatic logic lt_signed(input cpu_pkg::word_t a, input cpu_pkg::word_t b);
        if (a[31] != b[31]) begin
            return a[31];
        end
        return a < b;
    endfunction

    // reference result of an OP or OP-IMM instruction
    function automatic cpu_pkg::word_t ref_op(input logic [2:0] f3, input logic alt,
                                              input cpu_pkg::word_t a, input cpu_pkg::word_t b);
        cpu_pkg::word_t r;
        case (f3)
            3'd0: if (alt) r = a - b; else r = a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'd0, lt_signed(a, b)};
            3'd3: r = {31'd0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                r = a >> b[4:0];
                // sign fill for the arithmetic form
                if (alt && a[31]) begin
                    r = r | ~(32'hFFFF_FFFF >> b[4:0]);
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic ref_branch(input logic [2:0] f3, input cpu_pkg::word_t a,
                                        input cpu_pkg::word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return lt_signed(a, b);
            3'd5: return !lt_signed(a, b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic cpu_pkg::word_t ref_load(input cpu_pkg::word_t w, input logic [2:0] f3,
                                                input logic [1:0] off);
        logic [7:0]  by;
        logic [15:0] hw;
        by = w[8*off +: 8];
        hw = off[1] ? w[31:16] : w[15:0];
        case (f3)
            3'd0: return {{24{by[7]}}, by};
            3'd1: return {{16{hw[15]}}, hw};
            3'd4: return {24'd0, by};
            3'd5: return {16'd0, hw};
            default: return w;
        endcase
    endfunction

    task automatic check(input string name, input cpu_pkg::word_t actual,
                         input cpu_pkg::word_t expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h expected 0x%h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic put(input cpu_pkg::word_t w);
        prog.push_back(w);
    endtask

    task automatic expect_out(input cpu_pkg::word_t v);
        exp_q.push_back(v);
    endtask

    // lui plus addi, upper part rounded for the signed low half
    task automatic li(input logic [4:0] rd, input cpu_pkg::word_t v);
        cpu_pkg::word_t up;
        up = (v + 32'h800) >> 12;
        put(enc_u(up[19:0], rd, cpu_pkg::OPC_LUI));
        put(addi(rd, rd, v[11:0]));
    endtask

    task automatic out_reg(input logic [4:0] rs);
        put(enc_s(12'd0, rs, 5'd31, 3'b010));
    endtask

    // x31 holds the io address for the whole program
    task automatic start_prog();
        prog.delete();
        exp_q.delete();
        li(5'd31, `IO_OUT_ADDR);
    endtask

    task automatic finish_prog(input logic [4:0] rs);
        put(enc_i(`CSR_TOHOST, rs, 3'b001, 5'd0, cpu_pkg::OPC_SYSTEM));
        put(enc_j(21'd0, 5'd0));
    endtask

    task automatic run_program(input cpu_pkg::word_t exp_tohost);
        @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= cpu_pkg::mem_addr_t'(i);
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        check("io_valid", cpu_pkg::word_t'(io_valid), 32'd0);
        check("tohost_valid", cpu_pkg::word_t'(tohost_valid), 32'd0);
        check("tohost", tohost, 32'd0);
        io_q.delete();
        pulses = 0;
        @(posedge clk);
        rst <= 1'b0;
        // tohost stays clear until the csr write
        do begin
            @(negedge clk);
            if (!tohost_valid) begin
                check("tohost", tohost, 32'd0);
            end
        end while (!tohost_valid);
        check("tohost", tohost, exp_tohost);
        repeat (8) @(negedge clk);
        check("tohost_valid pulses", cpu_pkg::word_t'(pulses), 32'd1);
        if (io_q.size() != exp_q.size()) begin
            $display("wrong number of io outputs, got %0d expected %0d",
                     io_q.size(), exp_q.size());
            errors++;
        end
        for (int i = 0; i < io_q.size() && i < exp_q.size(); i++) begin
            check($sformatf("io_data[%0d]", i), io_q[i], exp_q[i]);
        end
    endtask

    task automatic finish_test(input string name, input int e0);
        if (errors == e0) begin
            $display("test %s: ok", name);
            n_pass++;
        end else begin
            $display("test %s: %0d errors", name, errors - e0);
            n_fail++;
        end
    endtask

    task automatic arith_test();
        int             e0;
        int             n;
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t r;
        logic [11:0]    i12;
        e0 = errors;
        a = random_word();
        b = random_word();
        start_prog();
        li(5'd1, a);
        li(5'd2, b);
        // k[3] is the alternate bit, k[2:0] funct3
        for (int k = 0; k < 16; k++) begin
            if (k[3] == 1'b0 || k[2:0] == 3'd0 || k[2:0] == 3'd5) begin
                put(enc_r(k[3] ? 7'h20 : 7'h00, 5'd2, 5'd1, k[2:0], 5'd3));
                out_reg(5'd3);
                expect_out(ref_op(k[2:0], k[3], a, b));
            end
        end
        for (int k = 0; k < 16; k++) begin
            if (k[3] == 1'b0 || k[2:0] == 3'd5) begin
                r = random_word();
                i12 = r[11:0];
                if (k[2:0] == 3'd1 || k[2:0] == 3'd5) begin
                    i12 = {1'b0, k[3], 5'd0, i12[4:0]};
                end
                put(enc_i(i12, 5'd1, k[2:0], 5'd3, cpu_pkg::OPC_OP_IMM));
                out_reg(5'd3);
                expect_out(ref_op(k[2:0], k[3], a, {{20{i12[11]}}, i12}));
            end
        end
        n = prog.size();
        put(enc_u(b[31:12], 5'd4, cpu_pkg::OPC_AUIPC));
        out_reg(5'd4);
        expect_out(pc_of(n) + {b[31:12], 12'd0});
        put(enc_u(a[31:12], 5'd5, cpu_pkg::OPC_LUI));
        out_reg(5'd5);
        expect_out({a[31:12], 12'd0});
        finish_prog(5'd1);
        run_program(a);
        finish_test("arith", e0);
    endtask

    task automatic chain_test();
        int             e0;
        cpu_pkg::word_t v [9];
        e0 = errors;
        v[1] = random_word();
        v[2] = v[1] + 32'd5;
        v[3] = v[2] + v[2];
        v[4] = v[3] - v[1];
        v[5] = v[4] ^ v[3];
        v[6] = v[5];
        v[7] = v[6] + 32'd1;
        v[8] = v[7] + v[6];
        start_prog();
        put(addi(5'd9, 5'd0, 12'h100));
        li(5'd1, v[1]);
        put(addi(5'd2, 5'd1, 12'd5));
        put(enc_r(7'h00, 5'd2, 5'd2, 3'd0, 5'd3));
        put(enc_r(7'h20, 5'd1, 5'd3, 3'd0, 5'd4));
        put(enc_r(7'h00, 5'd3, 5'd4, 3'd4, 5'd5));
        // store data and load result used with no gap
        put(enc_s(12'd0, 5'd5, 5'd9, 3'b010));
        put(enc_i(12'd0, 5'd9, 3'b010, 5'd6, cpu_pkg::OPC_LOAD));
        put(addi(5'd7, 5'd6, 12'd1));
        put(enc_r(7'h00, 5'd6, 5'd7, 3'd0, 5'd8));
        for (int r = 2; r <= 8; r++) begin
            out_reg(r[4:0]);
            expect_out(v[r]);
        end
        finish_prog(5'd8);
        run_program(v[8]);
        finish_test("chain", e0);
    endtask

    task automatic load_out(input logic [2:0] f3, input logic [1:0] off,
                            input cpu_pkg::word_t model);
        put(enc_i({10'd0, off}, 5'd2, f3, 5'd3, cpu_pkg::OPC_LOAD));
        out_reg(5'd3);
        expect_out(ref_load(model, f3, off));
    endtask

    task automatic mem_test();
        int             e0;
        cpu_pkg::word_t w;
        cpu_pkg::word_t h;
        cpu_pkg::word_t bt;
        cpu_pkg::word_t model;
        e0 = errors;
        w = random_word();
        h = random_word();
        bt = random_word();
        start_prog();
        li(5'd1, w);
        put(addi(5'd2, 5'd0, 12'h200));
        put(enc_s(12'd0, 5'd1, 5'd2, 3'b010));
        model = w;
        for (int off = 0; off < 4; off++) begin
            load_out(3'd0, off[1:0], model);
            load_out(3'd4, off[1:0], model);
            if (off[0] == 1'b0) begin
                load_out(3'd1, off[1:0], model);
                load_out(3'd5, off[1:0], model);
            end
        end
        load_out(3'd2, 2'd0, model);
        li(5'd4, h);
        put(enc_s(12'd2, 5'd4, 5'd2, 3'b001));
        model[31:16] = h[15:0];
        put(enc_s(12'd1, 5'd4, 5'd2, 3'b000));
        model[15:8] = h[7:0];
        load_out(3'd2, 2'd0, model);
        li(5'd5, bt);
        put(enc_s(12'd0, 5'd5, 5'd2, 3'b001));
        model[15:0] = bt[15:0];
        put(enc_s(12'd3, 5'd5, 5'd2, 3'b000));
        model[31:24] = bt[7:0];
        load_out(3'd2, 2'd0, model);
        load_out(3'd1, 2'd2, model);
        load_out(3'd0, 2'd3, model);
        finish_prog(5'd1);
        run_program(w);
        finish_test("load_store", e0);
    endtask

    task automatic branch_test();
        int             e0;
        int             k;
        logic [4:0]     r1;
        logic [4:0]     r2;
        cpu_pkg::word_t val [32];
        cpu_pkg::word_t t;
        e0 = errors;
        val[1] = 32'hFFFF_FFFB;
        val[2] = 32'd3;
        val[3] = 32'd3;
        start_prog();
        li(5'd1, val[1]);
        put(addi(5'd2, 5'd0, 12'd3));
        put(addi(5'd3, 5'd0, 12'd3));
        // x5 ends at 1 when taken, 2 when the next slot ran
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) begin
                continue;
            end
            for (int p = 0; p < 3; p++) begin
                r1 = (p == 0) ? 5'd1 : 5'd2;
                r2 = (p == 0) ? 5'd2 : (p == 1) ? 5'd1 : 5'd3;
                put(addi(5'd5, 5'd0, 12'd1));
                put(enc_b(13'd8, r2, r1, f[2:0]));
                put(addi(5'd5, 5'd0, 12'd2));
                out_reg(5'd5);
                expect_out(ref_branch(f[2:0], val[r1], val[r2]) ? 32'd1 : 32'd2);
            end
        end
        put(addi(5'd7, 5'd0, 12'd3));
        k = prog.size();
        put(enc_j(21'd8, 5'd6));
        put(addi(5'd7, 5'd0, 12'd7));
        out_reg(5'd6);
        out_reg(5'd7);
        expect_out(pc_of(k) + 32'd4);
        expect_out(32'd3);
        // jalr target plus one, low bit dropped by the cpu
        k = prog.size();
        t = pc_of(k + 5);
        put(addi(5'd8, 5'd0, t[11:0]));
        put(enc_i(12'd1, 5'd8, 3'b000, 5'd9, cpu_pkg::OPC_JALR));
        put(addi(5'd7, 5'd0, 12'd8));
        put(addi(5'd7, 5'd0, 12'd8));
        put(addi(5'd7, 5'd0, 12'd8));
        out_reg(5'd9);
        out_reg(5'd7);
        expect_out(pc_of(k + 1) + 32'd4);
        expect_out(32'd3);
        finish_prog(5'd9);
        run_program(pc_of(k + 1) + 32'd4);
        finish_test("branch_jump", e0);
    endtask

    task automatic reset_test();
        int             e0;
        cpu_pkg::word_t v1;
        cpu_pkg::word_t v2;
        e0 = errors;
        v1 = random_word();
        v2 = random_word();
        start_prog();
        li(5'd1, v1);
        out_reg(5'd1);
        expect_out(v1);
        finish_prog(5'd1);
        run_program(v1);
        // second program idles a while before it writes anything
        start_prog();
        repeat (6) put(cpu_pkg::NOP);
        li(5'd2, v2);
        out_reg(5'd2);
        expect_out(v2);
        finish_prog(5'd2);
        run_program(v2);
        finish_test("tohost_reset", e0);
    endtask

    initial begin
        rst       = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        repeat (10) @(posedge clk);
        arith_test();
        chain_test();
        mem_test();
        branch_test();
        reset_test();
        $display("tests passed %0d, tests failed %0d", n_pass, n_fail);
        if (errors == 0 && n_fail == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (NUM_TESTS * 2000) @(posedge clk);
        $display("watchdog expired before all tests finished");
        $display("Verification failed");
        $finish;
    end

endmodule

// File: cpu.f
+incdir+.
cpu_pkg.sv
word_ram.sv
reg_file.sv
alu.sv
imm_gen.sv
decode.sv
mem_align.sv
cpu.sv
tb_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= cpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
